//--- Makefile
# Verilator build and run of the execute stage testbench

SIM  := obj_dir/Vtb_ex_stage
SRCS := $(wildcard src/*.sv sim/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): ex_stage.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module tb_ex_stage -f ex_stage.f

# Exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir

//--- ex_stage.f
src/ex_pkg.sv
src/ex_alu.sv
src/ex_div.sv
src/ex_wb_pipe.sv
src/ex_stage.sv
sim/ex_stage_sva.sv
sim/tb_ex_stage.sv

//--- sim/ex_stage_sva.sv
/*
  Handshake assertions for the execute stage, bound into ex_stage.
  Checks that a stalled writeback item holds, that the divider rests
  in its idle state when no division is requested, and that writeback
  is empty right after reset.
*/

`timescale 1ns/1ns

module ex_stage_sva import ex_pkg::*; (
  input logic            clk,
  input logic            rst_n,
  input logic            valid_i,
  input logic            div_en_i,
  input logic            wb_ready_i,
  input logic            wb_valid_o,
  input logic            wb_rf_we_o,
  input logic [XLEN-1:0] wb_rf_wdata_o,
  input div_state_e      div_state_i
);

  // Stalled item stays put
  valid_held: assert property (@(posedge clk) disable iff (!rst_n)
    wb_valid_o && !wb_ready_i |=> wb_valid_o)
    else $error("wb_valid_o dropped while writeback stalled");

  data_held: assert property (@(posedge clk) disable iff (!rst_n)
    wb_valid_o && wb_rf_we_o && !wb_ready_i |=> $stable(wb_rf_wdata_o))
    else $error("wb_rf_wdata_o changed while writeback stalled");

  // Divider only leaves idle for a requested division
  div_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !(valid_i && div_en_i) |-> div_state_i == DIV_IDLE)
    else $error("divider busy with no division requested");

  reset_empty: assert property (@(posedge clk) $rose(rst_n) |-> !wb_valid_o)
    else $error("wb_valid_o high right after reset");

endmodule

bind ex_stage ex_stage_sva i_sva (
  .clk           (clk),
  .rst_n         (rst_n),
  .valid_i       (valid_i),
  .div_en_i      (div_en_i),
  .wb_ready_i    (wb_ready_i),
  .wb_valid_o    (wb_valid_o),
  .wb_rf_we_o    (wb_rf_we_o),
  .wb_rf_wdata_o (wb_rf_wdata_o),
  .div_state_i   (div_i.state_q)
);

//--- sim/tb_ex_stage.sv
/*
  Testbench for the execute stage.
  Drives random ALU and divider instructions from an LCG under random
  writeback back-pressure. Each accepted instruction is queued with its
  expected writeback values from a reference model, and a compare
  process checks every writeback transfer in acceptance order.
*/

`timescale 1ns/1ns

module tb_ex_stage import ex_pkg::*; ();

  localparam int NUM_INSTR      = 400;
  localparam int TIMEOUT_CYCLES = NUM_INSTR * 80;

  // Expected writeback item
  typedef struct packed {
    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic [XLEN-1:0]       rf_wdata;
    logic                  bch_taken;
  } wb_item_t;

  logic                  clk;
  logic                  rst_n;
  logic                  valid_i;
  logic                  alu_en_i;
  logic                  div_en_i;
  logic                  bch_i;
  logic                  rf_we_i;
  logic                  ex_ready_o;
  alu_op_e               alu_op_i;
  div_op_e               div_op_i;
  logic [XLEN-1:0]       operand_a_i;
  logic [XLEN-1:0]       operand_b_i;
  logic [XLEN-1:0]       operand_c_i;
  logic [REG_ADDR_W-1:0] rf_waddr_i;
  logic                  branch_decision_o;
  logic [XLEN-1:0]       branch_target_o;
  logic                  wb_valid_o;
  logic                  wb_rf_we_o;
  logic                  wb_bch_taken_o;
  logic                  wb_ready_i;
  logic [REG_ADDR_W-1:0] wb_rf_waddr_o;
  logic [XLEN-1:0]       wb_rf_wdata_o;

  logic [31:0] lcg_state   = 32'h9355_da86;
  int          cycle_count = 0;
  wb_item_t    expected_q[$];
  wb_item_t    wb_item;

  ex_stage i_dut (
    .clk               (clk),
    .rst_n             (rst_n),
    .valid_i           (valid_i),
    .alu_en_i          (alu_en_i),
    .div_en_i          (div_en_i),
    .alu_op_i          (alu_op_i),
    .div_op_i          (div_op_i),
    .operand_a_i       (operand_a_i),
    .operand_b_i       (operand_b_i),
    .operand_c_i       (operand_c_i),
    .bch_i             (bch_i),
    .rf_we_i           (rf_we_i),
    .rf_waddr_i        (rf_waddr_i),
    .ex_ready_o        (ex_ready_o),
    .branch_decision_o (branch_decision_o),
    .branch_target_o   (branch_target_o),
    .wb_valid_o        (wb_valid_o),
    .wb_rf_we_o        (wb_rf_we_o),
    .wb_rf_waddr_o     (wb_rf_waddr_o),
    .wb_rf_wdata_o     (wb_rf_wdata_o),
    .wb_bch_taken_o    (wb_bch_taken_o),
    .wb_ready_i        (wb_ready_i)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Random source and reference model
  ////////////////////////////////////////////////////////////

  // Halves swapped so the better upper bits land low
  function automatic logic [31:0] rand_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {lcg_state[15:0], lcg_state[31:16]};
  endfunction

  // Zero, all ones and the most negative value come up often
  function automatic logic [31:0] pick_operand();
    logic [31:0] r;
    r = rand_next();
    case (r[2:0])
      3'd0:    return '0;
      3'd1:    return '1;
      3'd2:    return 32'h8000_0000;
      3'd3:    return {24'd0, r[15:8]};
      default: return rand_next();
    endcase
  endfunction

  function automatic logic ref_compare(alu_op_e op, logic [31:0] a, logic [31:0] b);
    case (op)
      ALU_SLT, ALU_LT:   return $signed(a) < $signed(b);
      ALU_SLTU, ALU_LTU: return a < b;
      ALU_EQ:            return a == b;
      ALU_NE:            return a != b;
      ALU_GE:            return $signed(a) >= $signed(b);
      ALU_GEU:           return a >= b;
      default:           return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] ref_result(logic is_div, alu_op_e aop, div_op_e dop,
                                             logic [31:0] a, logic [31:0] b);
    logic        overflow;
    logic signed [31:0] sq;
    logic signed [31:0] sr;
    logic signed [31:0] sra;
    overflow = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    sq  = $signed(a) / $signed(b);
    sr  = $signed(a) % $signed(b);
    sra = $signed(a) >>> b[4:0];
    // RISC-V gives all ones for x/0 and x for x%0
    // Overflow gives the dividend and a zero remainder
    if (is_div) begin
      case (dop)
        DIV_DIV:  return (b == '0) ? '1 : (overflow ? a : sq);
        DIV_DIVU: return (b == '0) ? '1 : a / b;
        DIV_REM:  return (b == '0) ? a : (overflow ? '0 : sr);
        default:  return (b == '0) ? a : a % b;
      endcase
    end
    case (aop)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_SLL: return a << b[4:0];
      ALU_SRL: return a >> b[4:0];
      ALU_SRA: return sra;
      default: return {31'd0, ref_compare(aop, a, b)};
    endcase
  endfunction

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] expd);
    if (got !== expd) begin
      $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, expd);
      $display("Simulation FAILED");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  // Writeback stalls about one cycle in four
  task automatic next_cycle();
    @(posedge clk);
    #2;
    wb_ready_i = (rand_next() % 32'd4) != 32'd0;
  endtask

  task automatic drive_instr();
    logic [31:0] r;
    logic        is_div;
    r = rand_next();
    is_div      = (r[1:0] == 2'd0);
    valid_i     = 1'b1;
    alu_en_i    = !is_div;
    div_en_i    = is_div;
    alu_op_i    = alu_op_e'(r[7:4]);
    div_op_i    = div_op_e'(r[9:8]);
    operand_a_i = pick_operand();
    operand_b_i = pick_operand();
    // Now and then the signed overflow pair
    if (is_div && r[13:10] == 4'd0) begin
      operand_a_i = 32'h8000_0000;
      operand_b_i = '1;
    end
    operand_c_i = rand_next();
    bch_i       = !is_div && (alu_op_i >= ALU_EQ);
    rf_we_i     = (r[16:14] != 3'd0);
    rf_waddr_i  = r[21:17];
  endtask

  // Inputs held until the edge where valid and ready meet
  task automatic wait_accept();
    logic     accepted;
    wb_item_t item;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      check_value("branch_decision_o", 32'(branch_decision_o),
                  32'(alu_en_i && bch_i && ref_compare(alu_op_i, operand_a_i, operand_b_i)));
      check_value("branch_target_o", branch_target_o, operand_c_i);
      if (ex_ready_o) begin
        item.rf_we     = rf_we_i;
        item.rf_waddr  = rf_waddr_i;
        item.rf_wdata  = ref_result(div_en_i, alu_op_i, div_op_i, operand_a_i, operand_b_i);
        item.bch_taken = alu_en_i && bch_i && ref_compare(alu_op_i, operand_a_i, operand_b_i);
        expected_q.push_back(item);
        accepted = 1'b1;
      end else begin
        next_cycle();
      end
    end
  endtask

  initial begin
    int drain;
    rst_n       = 1'b0;
    valid_i     = 1'b0;
    alu_en_i    = 1'b0;
    div_en_i    = 1'b0;
    alu_op_i    = ALU_ADD;
    div_op_i    = DIV_DIV;
    bch_i       = 1'b0;
    operand_a_i = '0;
    operand_b_i = '0;
    operand_c_i = '0;
    rf_we_i     = 1'b0;
    rf_waddr_i  = '0;
    wb_ready_i  = 1'b1;
    repeat (5) @(posedge clk);
    #2 rst_n = 1'b1;
    // Reset state with ready following writeback
    @(negedge clk);
    check_value("wb_valid_o after reset", 32'(wb_valid_o), 32'd0);
    check_value("wb_rf_we_o after reset", 32'(wb_rf_we_o), 32'd0);
    check_value("ex_ready_o with wb ready", 32'(ex_ready_o), 32'd1);
    @(posedge clk);
    #2 wb_ready_i = 1'b0;
    @(negedge clk);
    check_value("ex_ready_o with wb stalled", 32'(ex_ready_o), 32'd0);
    for (int i = 0; i < NUM_INSTR; i++) begin
      next_cycle();
      // Occasional bubble from decode
      if (rand_next() % 32'd8 == 32'd0) begin
        valid_i = 1'b0;
        next_cycle();
      end
      drive_instr();
      wait_accept();
    end
    next_cycle();
    valid_i  = 1'b0;
    alu_en_i = 1'b0;
    div_en_i = 1'b0;
    drain = 0;
    while (expected_q.size() != 0 && drain < 50) begin
      @(negedge clk);
      next_cycle();
      drain++;
    end
    if (expected_q.size() == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      $display("Simulation FAILED");
      $fatal(1, "%0d accepted instructions never reached writeback", expected_q.size());
    end
  end

  ////////////////////////////////////////////////////////////
  // Writeback compare and timeout
  ////////////////////////////////////////////////////////////

  // Outputs are settled here and transfer at the next rising edge
  always @(negedge clk) begin
    if (rst_n && wb_valid_o && wb_ready_i) begin
      if (expected_q.size() == 0) begin
        $display("Simulation FAILED");
        $fatal(1, "Writeback transfer with no accepted instruction pending");
      end else begin
        wb_item = expected_q.pop_front();
        check_value("wb_rf_we_o", 32'(wb_rf_we_o), 32'(wb_item.rf_we));
        check_value("wb_bch_taken_o", 32'(wb_bch_taken_o), 32'(wb_item.bch_taken));
        // Address and data only move on register writes
        if (wb_item.rf_we) begin
          check_value("wb_rf_waddr_o", 32'(wb_rf_waddr_o), 32'(wb_item.rf_waddr));
          check_value("wb_rf_wdata_o", wb_rf_wdata_o, wb_item.rf_wdata);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Simulation FAILED");
      $fatal(1, "Timeout, run went past %0d cycles", TIMEOUT_CYCLES);
    end
  end

endmodule

//--- src/ex_alu.sv
/*
  Single-cycle ALU of the execute stage.
  Computes add/sub, logic ops, shifts, set-less-than and the six branch
  compares. The leading-zero counter and the shifter are also lent to
  the divider through the clz_* and shift_* ports while a division
  is aligning its divisor.
*/

`timescale 1ns/1ns

module ex_alu import ex_pkg::*; (
  input  alu_op_e            operator_i,
  input  logic [XLEN-1:0]    operand_a_i,
  input  logic [XLEN-1:0]    operand_b_i,

  // Divider borrow ports
  input  logic               clz_en_i,
  input  logic [XLEN-1:0]    clz_data_i,
  input  logic               shift_en_i,
  input  logic [CLZ_W-1:0]   shift_amt_i,

  output logic [XLEN-1:0]    result_o,
  output logic               cmp_result_o,
  output logic [CLZ_W-1:0]   clz_result_o,
  output logic [XLEN-1:0]    op_b_shifted_o
);

  logic [XLEN-1:0]  adder_result;
  logic             is_sub;
  logic             lt_signed;
  logic             lt_unsigned;
  logic             is_equal;

  logic             shift_left;
  logic             shift_arith;
  logic [XLEN-1:0]  shift_src;
  logic [CLZ_W-1:0] shift_amt;
  logic [XLEN-1:0]  shift_in;
  logic [XLEN:0]    shift_ext;
  logic [XLEN:0]    shift_right;
  logic [XLEN-1:0]  shift_result;

  logic [CLZ_W-1:0] clz_count;

  ////////////////////////////////////////////////////////////
  // Adder and comparator
  ////////////////////////////////////////////////////////////

  // Subtract as a + ~b + 1
  assign is_sub       = (operator_i == ALU_SUB);
  assign adder_result = operand_a_i + (is_sub ? ~operand_b_i : operand_b_i) + XLEN'(is_sub);

  assign is_equal    = (operand_a_i == operand_b_i);
  assign lt_signed   = ($signed(operand_a_i) < $signed(operand_b_i));
  assign lt_unsigned = (operand_a_i < operand_b_i);

  // One comparator serves SLT(U) and all branch compares
  always_comb begin
    case (operator_i)
      ALU_SLT, ALU_LT:   cmp_result_o = lt_signed;
      ALU_SLTU, ALU_LTU: cmp_result_o = lt_unsigned;
      ALU_EQ:            cmp_result_o = is_equal;
      ALU_NE:            cmp_result_o = !is_equal;
      ALU_GE:            cmp_result_o = !lt_signed;
      ALU_GEU:           cmp_result_o = !lt_unsigned;
      default:           cmp_result_o = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Shifter
  ////////////////////////////////////////////////////////////

  // Divider takes over the shifter, always a left shift of operand b
  assign shift_left  = shift_en_i || (operator_i == ALU_SLL);
  assign shift_arith = !shift_en_i && (operator_i == ALU_SRA);
  assign shift_src   = shift_en_i ? operand_b_i : operand_a_i;
  assign shift_amt   = shift_en_i ? shift_amt_i : {1'b0, operand_b_i[4:0]};

  // Left shift is a right shift on the bit-reversed operand
  assign shift_in     = shift_left ? {<<{shift_src}} : shift_src;
  assign shift_ext    = {shift_arith & shift_in[XLEN-1], shift_in};
  assign shift_right  = $unsigned($signed(shift_ext) >>> shift_amt);
  assign shift_result = shift_left ? {<<{shift_right[XLEN-1:0]}} : shift_right[XLEN-1:0];

  assign op_b_shifted_o = shift_result;

  ////////////////////////////////////////////////////////////
  // Leading-zero count
  ////////////////////////////////////////////////////////////

  // Highest set bit wins, zero data counts as XLEN
  always_comb begin
    clz_count = CLZ_W'(XLEN);
    for (int i = 0; i < XLEN; i++) begin
      if (clz_data_i[i]) begin
        clz_count = CLZ_W'(XLEN - 1 - i);
      end
    end
  end

  assign clz_result_o = clz_en_i ? clz_count : '0;

  // Result select
  always_comb begin
    case (operator_i)
      ALU_ADD, ALU_SUB:          result_o = adder_result;
      ALU_AND:                   result_o = operand_a_i & operand_b_i;
      ALU_OR:                    result_o = operand_a_i | operand_b_i;
      ALU_XOR:                   result_o = operand_a_i ^ operand_b_i;
      ALU_SLL, ALU_SRL, ALU_SRA: result_o = shift_result;
      // Set-less-than and branch compares return the flag
      default:                   result_o = {{(XLEN-1){1'b0}}, cmp_result_o};
    endcase
  end

endmodule

//--- src/ex_div.sv
/*
  Iterative divider for DIV, DIVU, REM and REMU.
  Works on operand magnitudes, aligns the divisor with the ALU's CLZ and
  shifter, then produces one quotient bit per cycle with a restoring
  subtract. Signs are applied on the output. valid_i starts a division,
  valid_o flags the result, which is held until ready_i.
*/

`timescale 1ns/1ns

module ex_div import ex_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,

  input  div_op_e           operator_i,
  input  logic [XLEN-1:0]   op_a_i,
  input  logic [XLEN-1:0]   op_b_i,

  // Handshake
  input  logic              valid_i,
  input  logic              ready_i,
  output logic              valid_o,
  output logic              ready_o,

  // Borrowed ALU resources
  input  logic [CLZ_W-1:0]  clz_result_i,
  input  logic [XLEN-1:0]   op_b_shifted_i,
  output logic              clz_en_o,
  output logic [XLEN-1:0]   clz_data_o,
  output logic              shift_en_o,
  output logic [CLZ_W-1:0]  shift_amt_o,

  output logic [XLEN-1:0]   result_o
);

  div_state_e       state_q;
  div_state_e       state_d;
  logic [CLZ_W-1:0] cnt_q;

  logic [XLEN-1:0]  rem_q;
  logic [XLEN-1:0]  quot_q;
  logic [XLEN-1:0]  div_q;

  logic             is_signed;
  logic             is_rem;
  logic             a_neg;
  logic             b_neg;
  logic             b_zero;
  logic             quot_neg;
  logic [XLEN-1:0]  a_mag;
  logic [XLEN-1:0]  b_mag;
  logic [XLEN:0]    sub_diff;

  // Operands stay stable until the stage accepts the result
  assign is_signed = (operator_i == DIV_DIV) || (operator_i == DIV_REM);
  assign is_rem    = (operator_i == DIV_REM) || (operator_i == DIV_REMU);
  assign a_neg     = is_signed && op_a_i[XLEN-1];
  assign b_neg     = is_signed && op_b_i[XLEN-1];
  assign b_zero    = (op_b_i == '0);
  assign a_mag     = a_neg ? -op_a_i : op_a_i;
  assign b_mag     = b_neg ? -op_b_i : op_b_i;
  // Division by zero keeps the all-ones quotient unsigned
  assign quot_neg  = (a_neg ^ b_neg) && !b_zero;

  // Trial subtract, top bit is the borrow
  assign sub_diff = {1'b0, rem_q} - {1'b0, div_q};

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      DIV_IDLE:  if (valid_i) state_d = b_zero ? DIV_DONE : DIV_ALIGN;
      DIV_ALIGN: state_d = DIV_ITER;
      DIV_ITER:  if (cnt_q == '0) state_d = DIV_DONE;
      DIV_DONE:  if (ready_i) state_d = DIV_IDLE;
      default:   state_d = DIV_IDLE;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q <= DIV_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      // Iterations left, one per quotient bit
      if (state_q == DIV_ALIGN) begin
        cnt_q <= clz_result_i;
      end else if (state_q == DIV_ITER) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // Datapath
  always_ff @(posedge clk) begin
    case (state_q)
      DIV_IDLE: if (valid_i) begin
        rem_q  <= a_mag;
        quot_q <= b_zero ? '1 : '0;
      end
      // Shifted raw divisor, negated back to a magnitude when needed
      DIV_ALIGN: div_q <= b_neg ? -op_b_shifted_i : op_b_shifted_i;
      DIV_ITER: begin
        if (!sub_diff[XLEN]) begin
          rem_q <= sub_diff[XLEN-1:0];
        end
        quot_q <= {quot_q[XLEN-2:0], !sub_diff[XLEN]};
        div_q  <= div_q >> 1;
      end
      default: ;
    endcase
  end

  // CLZ result feeds the shift amount in the same cycle
  assign clz_en_o    = (state_q == DIV_ALIGN);
  assign clz_data_o  = b_mag;
  assign shift_en_o  = (state_q == DIV_ALIGN);
  assign shift_amt_o = clz_result_i;

  assign valid_o = (state_q == DIV_DONE);
  // Busy once a request shows up, free again when the result leaves
  assign ready_o = ((state_q == DIV_IDLE) && !valid_i) || ((state_q == DIV_DONE) && ready_i);

  // Remainder takes the dividend's sign
  assign result_o = is_rem ? (a_neg ? -rem_q : rem_q) : (quot_neg ? -quot_q : quot_q);

endmodule

//--- src/ex_pkg.sv
/*
  Shared definitions for the execute stage.
  Holds the data and register address widths, the ALU and divider
  opcode encodings and the divider FSM state encoding. Every RTL file
  and the testbench pull these in with a wildcard import.
*/

package ex_pkg;

  // Operand and result width
  localparam int unsigned XLEN       = 32;
  // Register file address width
  localparam int unsigned REG_ADDR_W = 5;
  // Leading-zero count and shift amount, range 0 to 32
  localparam int unsigned CLZ_W      = 6;

  // ALU operations, grouped as arithmetic/logic, shifts and compares
  typedef enum logic [3:0] {
    ALU_ADD  = 4'h0,
    ALU_SUB  = 4'h1,
    ALU_AND  = 4'h2,
    ALU_OR   = 4'h3,
    ALU_XOR  = 4'h4,
    ALU_SLL  = 4'h5,
    ALU_SRL  = 4'h6,
    ALU_SRA  = 4'h7,
    ALU_SLT  = 4'h8,
    ALU_SLTU = 4'h9,
    ALU_EQ   = 4'hA,
    ALU_NE   = 4'hB,
    ALU_LT   = 4'hC,
    ALU_GE   = 4'hD,
    ALU_LTU  = 4'hE,
    ALU_GEU  = 4'hF
  } alu_op_e;

  // Divider operations
  typedef enum logic [1:0] {
    DIV_DIV  = 2'b00,
    DIV_DIVU = 2'b01,
    DIV_REM  = 2'b10,
    DIV_REMU = 2'b11
  } div_op_e;

  // Divider FSM states
  typedef enum logic [1:0] {
    DIV_IDLE  = 2'b00,
    DIV_ALIGN = 2'b01,
    DIV_ITER  = 2'b10,
    DIV_DONE  = 2'b11
  } div_state_e;

endpackage

//--- src/ex_stage.sv
/*
  Execute stage top level.
  Hosts the ALU, the iterative divider and the EX/WB register. Accepts
  one instruction per valid/ready handshake from decode, gives the branch
  decision in the same cycle and hands results to writeback through the
  pipeline register.
*/

`timescale 1ns/1ns

module ex_stage import ex_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,

  // From decode
  input  logic                  valid_i,
  input  logic                  alu_en_i,
  input  logic                  div_en_i,
  input  alu_op_e               alu_op_i,
  input  div_op_e               div_op_i,
  input  logic [XLEN-1:0]       operand_a_i,
  input  logic [XLEN-1:0]       operand_b_i,
  input  logic [XLEN-1:0]       operand_c_i,
  input  logic                  bch_i,
  input  logic                  rf_we_i,
  input  logic [REG_ADDR_W-1:0] rf_waddr_i,
  output logic                  ex_ready_o,

  // Branch decision and target
  output logic                  branch_decision_o,
  output logic [XLEN-1:0]       branch_target_o,

  // To writeback
  output logic                  wb_valid_o,
  output logic                  wb_rf_we_o,
  output logic [REG_ADDR_W-1:0] wb_rf_waddr_o,
  output logic [XLEN-1:0]       wb_rf_wdata_o,
  output logic                  wb_bch_taken_o,
  input  logic                  wb_ready_i
);

  logic             alu_en_gated;
  logic             div_en_gated;
  logic             ex_valid;
  logic [XLEN-1:0]  ex_result;

  logic [XLEN-1:0]  alu_result;
  logic             alu_cmp_result;
  logic [XLEN-1:0]  div_result;
  logic             div_valid;
  logic             div_ready;

  // Divider use of ALU resources
  logic             div_clz_en;
  logic [XLEN-1:0]  div_clz_data;
  logic [CLZ_W-1:0] div_clz_result;
  logic             div_shift_en;
  logic [CLZ_W-1:0] div_shift_amt;
  logic [XLEN-1:0]  div_op_b_shifted;

  assign alu_en_gated = alu_en_i && valid_i;
  assign div_en_gated = div_en_i && valid_i;

  // Branch taken only for a valid ALU branch
  assign branch_decision_o = alu_en_gated && bch_i && alu_cmp_result;
  assign branch_target_o   = operand_c_i;

  ////////////////////////////////////////////////////////////
  // Functional units
  ////////////////////////////////////////////////////////////

  ex_alu alu_i (
    .operator_i     (alu_op_i),
    .operand_a_i    (operand_a_i),
    .operand_b_i    (operand_b_i),
    .clz_en_i       (div_clz_en),
    .clz_data_i     (div_clz_data),
    .shift_en_i     (div_shift_en),
    .shift_amt_i    (div_shift_amt),
    .result_o       (alu_result),
    .cmp_result_o   (alu_cmp_result),
    .clz_result_o   (div_clz_result),
    .op_b_shifted_o (div_op_b_shifted)
  );

  ex_div div_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .operator_i     (div_op_i),
    .op_a_i         (operand_a_i),
    .op_b_i         (operand_b_i),
    .valid_i        (div_en_gated),
    .ready_i        (wb_ready_i),
    .valid_o        (div_valid),
    .ready_o        (div_ready),
    .clz_result_i   (div_clz_result),
    .op_b_shifted_i (div_op_b_shifted),
    .clz_en_o       (div_clz_en),
    .clz_data_o     (div_clz_data),
    .shift_en_o     (div_shift_en),
    .shift_amt_o    (div_shift_amt),
    .result_o       (div_result)
  );

  // Result select, the write enable masks junk on invalid cycles
  assign ex_result = div_en_i ? div_result : alu_result;

  // ALU is single-cycle, the divider reports its own completion
  assign ex_valid   = alu_en_gated || (div_en_gated && div_valid);
  assign ex_ready_o = wb_ready_i && (!div_en_i || div_ready);

  ex_wb_pipe wb_pipe_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .ex_valid_i     (ex_valid),
    .wb_ready_i     (wb_ready_i),
    .rf_we_i        (rf_we_i),
    .rf_waddr_i     (rf_waddr_i),
    .rf_wdata_i     (ex_result),
    .bch_taken_i    (branch_decision_o),
    .wb_valid_o     (wb_valid_o),
    .wb_rf_we_o     (wb_rf_we_o),
    .wb_rf_waddr_o  (wb_rf_waddr_o),
    .wb_rf_wdata_o  (wb_rf_wdata_o),
    .wb_bch_taken_o (wb_bch_taken_o)
  );

endmodule

//--- src/ex_wb_pipe.sv
/*
  EX/WB pipeline register.
  Loads an item when the stage is valid and writeback is ready, drops
  in a bubble when writeback is ready but nothing arrives, and holds
  everything while writeback stalls.
*/

`timescale 1ns/1ns

module ex_wb_pipe import ex_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  ex_valid_i,
  input  logic                  wb_ready_i,
  input  logic                  rf_we_i,
  input  logic [REG_ADDR_W-1:0] rf_waddr_i,
  input  logic [XLEN-1:0]       rf_wdata_i,
  input  logic                  bch_taken_i,

  output logic                  wb_valid_o,
  output logic                  wb_rf_we_o,
  output logic [REG_ADDR_W-1:0] wb_rf_waddr_o,
  output logic [XLEN-1:0]       wb_rf_wdata_o,
  output logic                  wb_bch_taken_o
);

  logic load;

  assign load = ex_valid_i && wb_ready_i;

  // Qualifiers
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      wb_valid_o     <= 1'b0;
      wb_rf_we_o     <= 1'b0;
      wb_bch_taken_o <= 1'b0;
    end else if (load) begin
      wb_valid_o     <= 1'b1;
      wb_rf_we_o     <= rf_we_i;
      wb_bch_taken_o <= bch_taken_i;
    end else if (wb_ready_i) begin
      // Nothing to pass on, insert a bubble
      wb_valid_o     <= 1'b0;
      wb_rf_we_o     <= 1'b0;
      wb_bch_taken_o <= 1'b0;
    end
  end

  // Address and data only move for register writes
  always_ff @(posedge clk) begin
    if (load && rf_we_i) begin
      wb_rf_waddr_o <= rf_waddr_i;
      wb_rf_wdata_o <= rf_wdata_i;
    end
  end

endmodule
